// File: eth_example_ctrl.f
+incdir+include
source/eth_ctrl_pkg.sv
source/input_sync.sv
source/link_supervisor.sv
source/stats_serializer.sv
source/eth_example_ctrl.sv
sim/tb_eth_example_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 \
   -f eth_example_ctrl.f \
   --top-module tb_eth_example_ctrl \
   -o sim_tb_eth_example_ctrl &&
./obj_dir/sim_tb_eth_example_ctrl | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }

// File: include/tb_helpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// ------------------------------
// Random source
// ------------------------------

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
   if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
   end
   return state >> 1;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------

// Common failure path, stops the run at the first mismatch
task automatic report_mismatch(input string name, input string expected, input string actual);
   $display("** Error at %0t: %s expected %s, got %s", $time, name, expected, actual);
   $display("Something failed");
   $fatal(1);
endtask

task automatic check_mac_config(input string name,
                                input eth_ctrl_pkg::mac_config_t expected,
                                input eth_ctrl_pkg::mac_config_t actual);
   if (actual !== expected) begin
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
   end
endtask

task automatic check_pcs_config(input string name,
                                input eth_ctrl_pkg::pcs_config_t expected,
                                input eth_ctrl_pkg::pcs_config_t actual);
   if (actual !== expected) begin
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
   end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
   end
endtask

`endif

// File: sim/tb_eth_example_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_example_ctrl;

   `include "tb_helpers.svh"

   // ------------------------------
   // Run lengths in cycles
   // ------------------------------
   localparam int RESET_CYCLES  = 5;
   localparam int SYNC_CYCLES   = 150;
   localparam int COUNT_CYCLES  = 200;
   localparam int STATUS_CYCLES = 300;
   localparam int FRAMES_PER_CH = 6;
   localparam int TAIL_CYCLES   = 6;
   localparam int FRAME_CYCLES  = eth_ctrl_pkg::STATS_MAX_WIDTH + 2 + TAIL_CYCLES + 2;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + SYNC_CYCLES + COUNT_CYCLES + STATUS_CYCLES
                                  + eth_ctrl_pkg::NUM_STATS_CH * FRAMES_PER_CH * FRAME_CYCLES;
   localparam int TIMEOUT_CYCLES = (TOTAL_CYCLES * 3) / 2;

   logic                                      coreclk = 1'b0;
   logic                                      reset;
   logic                                      pcs_loopback;
   logic                                      enable_custom_preamble;
   logic                                      enable_pat_gen;
   logic [eth_ctrl_pkg::PCS_STATUS_WIDTH-1:0] pcspma_status;
   eth_ctrl_pkg::mac_status_t                 mac_status;
   logic                                      resetdone;
   eth_ctrl_pkg::stats_report_t               stats [eth_ctrl_pkg::NUM_STATS_CH];
   eth_ctrl_pkg::mac_config_t                 mac_tx_config;
   eth_ctrl_pkg::mac_config_t                 mac_rx_config;
   eth_ctrl_pkg::pcs_config_t                 pcs_config;
   logic                                      core_ready;
   logic                                      pat_gen_start;
   logic [eth_ctrl_pkg::NUM_STATS_CH-1:0]     serialized_stats;

   // Reference model state
   eth_ctrl_pkg::ctrl_sync_t         ctrl_d1;
   eth_ctrl_pkg::ctrl_sync_t         ctrl_d2;
   logic                             resetdone_seen;
   logic [1:0]                       edge_count;
   logic [eth_ctrl_pkg::STATS_MAX_WIDTH-1:0] loaded_vec [eth_ctrl_pkg::NUM_STATS_CH];

   // Channel that is sending a frame, all others must stay low
   int          framing_ch = -1;

   logic [31:0] lfsr_state = 32'h98f46b29;
   int          cycle_count = 0;

   always #50 coreclk = ~coreclk;

   eth_example_ctrl DUT (
      .coreclk                (coreclk),
      .reset                  (reset),
      .pcs_loopback           (pcs_loopback),
      .enable_custom_preamble (enable_custom_preamble),
      .enable_pat_gen         (enable_pat_gen),
      .pcspma_status          (pcspma_status),
      .mac_status             (mac_status),
      .resetdone              (resetdone),
      .stats                  (stats),
      .mac_tx_config          (mac_tx_config),
      .mac_rx_config          (mac_rx_config),
      .pcs_config             (pcs_config),
      .core_ready             (core_ready),
      .pat_gen_start          (pat_gen_start),
      .serialized_stats       (serialized_stats)
   );

   // ------------------------------
   // Random bits and expected values
   // ------------------------------
   function automatic logic draw_bit();
      lfsr_state = lfsr_step(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic logic [31:0] draw_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], draw_bit()};
      end
      return value;
   endfunction

   // Fields from the top bit down with the preamble at bit 7
   function automatic eth_ctrl_pkg::mac_config_t expected_mac(input eth_ctrl_pkg::ctrl_sync_t c);
      return {72'b0, c.custom_preamble, 4'b0, eth_ctrl_pkg::VLAN_ENABLE, eth_ctrl_pkg::MAC_MODE};
   endfunction

   function automatic eth_ctrl_pkg::pcs_config_t expected_pcs(input eth_ctrl_pkg::ctrl_sync_t c);
      return {425'b0, c.pcs_loopback, 110'b0};
   endfunction

   // Step the model on the rising edge with the inputs the DUT sees
   task automatic advance();
      @(posedge coreclk);
      if (reset) begin
         ctrl_d1        = '0;
         ctrl_d2        = '0;
         resetdone_seen = 1'b0;
         edge_count     = 2'd0;
      end
      else begin
         ctrl_d2                 = ctrl_d1;
         ctrl_d1.pcs_loopback    = pcs_loopback;
         ctrl_d1.custom_preamble = enable_custom_preamble;
         if (resetdone && !resetdone_seen) begin
            edge_count = edge_count + 2'd1;
         end
         resetdone_seen = resetdone;
      end
   endtask

   // Outputs are settled by the falling edge
   task automatic check_link();
      logic fault_free;
      logic ready_exp;
      logic start_exp;
      @(negedge coreclk);
      // Remote fault in bit 0 and local fault in bit 1 both clear
      fault_free = (mac_status[1:0] == 2'b00);
      // Ready only while the counter sits at 2 or 3
      ready_exp  = pcspma_status[0] && fault_free && (edge_count >= 2'd2);
      start_exp  = 1'b0;
      if (enable_pat_gen && fault_free) begin
         start_exp = ctrl_d2.pcs_loopback || pcspma_status[0];
      end
      check_mac_config("mac_tx_config", expected_mac(ctrl_d2), mac_tx_config);
      check_mac_config("mac_rx_config", expected_mac(ctrl_d2), mac_rx_config);
      check_pcs_config("pcs_config", expected_pcs(ctrl_d2), pcs_config);
      check_bit("core_ready", ready_exp, core_ready);
      check_bit("pat_gen_start", start_exp, pat_gen_start);
      for (int c = 0; c < eth_ctrl_pkg::NUM_STATS_CH; c++) begin
         if (c != framing_ch) begin
            check_bit($sformatf("serialized_stats[%0d]", c), 1'b0, serialized_stats[c]);
         end
      end
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      logic [31:0] rnd;
      int          width;
      reset                  = 1'b1;
      pcs_loopback           = 1'b0;
      enable_custom_preamble = 1'b0;
      enable_pat_gen         = 1'b0;
      pcspma_status          = '0;
      mac_status             = '0;
      resetdone              = 1'b0;
      for (int c = 0; c < eth_ctrl_pkg::NUM_STATS_CH; c++) begin
         stats[c] = '0;
      end

      // Reset values
      for (int i = 0; i < RESET_CYCLES; i++) begin
         advance();
         if (i == RESET_CYCLES - 1) begin
            reset <= 1'b0;
         end
         check_link();
      end

      // Control toggles through the synchronizer
      for (int i = 0; i < SYNC_CYCLES; i++) begin
         advance();
         pcs_loopback           <= draw_bit();
         enable_custom_preamble <= draw_bit();
         check_link();
      end

      // Reset-done edges with a healthy link
      advance();
      pcspma_status <= 8'h01;
      mac_status    <= '0;
      check_link();
      for (int i = 0; i < COUNT_CYCLES; i++) begin
         advance();
         resetdone <= draw_bit() & draw_bit();
         check_link();
      end

      // Random status, fault and generator enable
      for (int i = 0; i < STATUS_CYCLES; i++) begin
         advance();
         rnd = draw_bits(14);
         pcspma_status          <= rnd[7:0];
         mac_status             <= rnd[10:8];
         enable_pat_gen         <= rnd[11];
         pcs_loopback           <= rnd[12];
         resetdone              <= rnd[13];
         check_link();
      end

      // Statistics frames with valid held high past the frame
      for (int c = 0; c < eth_ctrl_pkg::NUM_STATS_CH; c++) begin
         width      = eth_ctrl_pkg::STATS_WIDTH[c];
         framing_ch = c;
         for (int f = 0; f < FRAMES_PER_CH; f++) begin
            advance();
            rnd           = draw_bits(width);
            loaded_vec[c] = rnd[eth_ctrl_pkg::STATS_MAX_WIDTH-1:0];
            stats[c].vector <= loaded_vec[c];
            stats[c].valid  <= 1'b1;
            check_link();
            while (serialized_stats[c] !== 1'b1) begin
               advance();
               check_link();
            end
            for (int i = width - 1; i >= 0; i--) begin
               advance();
               check_link();
               check_bit($sformatf("serialized_stats[%0d]", c), loaded_vec[c][i],
                         serialized_stats[c]);
            end
            for (int i = 0; i < TAIL_CYCLES; i++) begin
               advance();
               check_link();
               check_bit($sformatf("serialized_stats[%0d]", c), 1'b0, serialized_stats[c]);
            end
            advance();
            stats[c].valid <= 1'b0;
            check_link();
         end
      end

      $display("Everything OK");
      $finish;
   end

   // ------------------------------
   // Run limit
   // ------------------------------
   always @(posedge coreclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the test did not reach its end", cycle_count);
         $display("Something failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: source/eth_example_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eth_example_ctrl (
   input  logic                                      coreclk,
   input  logic                                      reset,

   // Example design controls
   input  logic                                      pcs_loopback,
   input  logic                                      enable_custom_preamble,
   input  logic                                      enable_pat_gen,

   // Core status
   input  logic [eth_ctrl_pkg::PCS_STATUS_WIDTH-1:0] pcspma_status,
   input  eth_ctrl_pkg::mac_status_t                 mac_status,
   input  logic                                      resetdone,

   // Core statistics, one entry per channel
   input  eth_ctrl_pkg::stats_report_t               stats [eth_ctrl_pkg::NUM_STATS_CH],

   // Core configuration
   output eth_ctrl_pkg::mac_config_t                 mac_tx_config,
   output eth_ctrl_pkg::mac_config_t                 mac_rx_config,
   output eth_ctrl_pkg::pcs_config_t                 pcs_config,

   // Example design status
   output logic                                      core_ready,
   output logic                                      pat_gen_start,
   output logic [eth_ctrl_pkg::NUM_STATS_CH-1:0]     serialized_stats
);

   eth_ctrl_pkg::ctrl_sync_t ctrl_async;
   eth_ctrl_pkg::ctrl_sync_t ctrl_sync;

   // ------------------------------
   // Control synchronization
   // ------------------------------
   assign ctrl_async.pcs_loopback    = pcs_loopback;
   assign ctrl_async.custom_preamble = enable_custom_preamble;

   input_sync u_input_sync (
      .coreclk  (coreclk),
      .reset    (reset),
      .async_in (ctrl_async),
      .sync_out (ctrl_sync)
   );

   // ------------------------------
   // Configuration and link status
   // ------------------------------

   // Status inputs already live in coreclk
   link_supervisor u_link_supervisor (
      .coreclk        (coreclk),
      .reset          (reset),
      .enable_pat_gen (enable_pat_gen),
      .ctrl           (ctrl_sync),
      .pcspma_status  (pcspma_status),
      .mac_status     (mac_status),
      .resetdone      (resetdone),
      .mac_tx_config  (mac_tx_config),
      .mac_rx_config  (mac_rx_config),
      .pcs_config     (pcs_config),
      .core_ready     (core_ready),
      .pat_gen_start  (pat_gen_start)
   );

   // ------------------------------
   // Statistics serializers
   // ------------------------------

   // Channel 0 is transmit, channel 1 is receive
   for (genvar c = 0; c < eth_ctrl_pkg::NUM_STATS_CH; c++) begin : g_stats
      stats_serializer #(
         .VECTOR_WIDTH (eth_ctrl_pkg::STATS_WIDTH[c])
      ) u_stats_serializer (
         .coreclk    (coreclk),
         .reset      (reset),
         .report     (stats[c]),
         .serial_out (serialized_stats[c])
      );
   end

endmodule

`default_nettype wire

// File: source/stats_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module stats_serializer #(
   parameter int VECTOR_WIDTH = eth_ctrl_pkg::STATS_MAX_WIDTH
) (
   input  logic                        coreclk,
   input  logic                        reset,
   input  eth_ctrl_pkg::stats_report_t report,
   output logic                        serial_out
);

   // Marker plus vector
   localparam int SHIFT_WIDTH = VECTOR_WIDTH + 2;

   logic                   valid_q;
   logic                   load;
   logic [SHIFT_WIDTH-1:0] shift_q;

   // ------------------------------
   // Valid edge detect
   // ------------------------------
   always_ff @(posedge coreclk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end
      else begin
         valid_q <= report.valid;
      end
   end

   // Valid is a level, only its rising edge starts a frame
   assign load = report.valid && !valid_q;

   // ------------------------------
   // Shift register
   // ------------------------------

   // A new load restarts the frame even mid-shift
   always_ff @(posedge coreclk) begin
      if (reset) begin
         shift_q <= '0;
      end
      else if (load) begin
         shift_q <= {eth_ctrl_pkg::STATS_MARKER, report.vector[VECTOR_WIDTH-1:0]};
      end
      else begin
         shift_q <= {shift_q[SHIFT_WIDTH-2:0], 1'b0};
      end
   end

   // MSB first, the 0,1 marker leads
   assign serial_out = shift_q[SHIFT_WIDTH-1];

endmodule

`default_nettype wire

// File: source/link_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module link_supervisor (
   input  logic                                      coreclk,
   input  logic                                      reset,
   input  logic                                      enable_pat_gen,
   input  eth_ctrl_pkg::ctrl_sync_t                  ctrl,
   input  logic [eth_ctrl_pkg::PCS_STATUS_WIDTH-1:0] pcspma_status,
   input  eth_ctrl_pkg::mac_status_t                 mac_status,
   input  logic                                      resetdone,
   output eth_ctrl_pkg::mac_config_t                 mac_tx_config,
   output eth_ctrl_pkg::mac_config_t                 mac_rx_config,
   output eth_ctrl_pkg::pcs_config_t                 pcs_config,
   output logic                                      core_ready,
   output logic                                      pat_gen_start
);

   logic                      block_lock;
   logic                      no_fault;
   logic                      resetdone_q;
   logic                      resetdone_rise;
   logic [1:0]                resetdone_count;
   eth_ctrl_pkg::mac_config_t mac_cfg;
   eth_ctrl_pkg::pcs_config_t pcs_cfg;

   // ------------------------------
   // Configuration vectors
   // ------------------------------

   // TX and RX MAC settings are identical
   always_comb begin
      mac_cfg                 = '0;
      mac_cfg.custom_preamble = ctrl.custom_preamble;
      mac_cfg.enable_vlan     = eth_ctrl_pkg::VLAN_ENABLE;
      mac_cfg.mode            = eth_ctrl_pkg::MAC_MODE;
   end

   assign mac_tx_config = mac_cfg;
   assign mac_rx_config = mac_cfg;

   // Only the loopback bit is ever set on the PCS side
   always_comb begin
      pcs_cfg          = '0;
      pcs_cfg.loopback = ctrl.pcs_loopback;
   end

   assign pcs_config = pcs_cfg;

   // ------------------------------
   // Link status
   // ------------------------------
   assign block_lock = pcspma_status[0];

   // Receive fault is not part of the check
   assign no_fault = !mac_status.remote_fault && !mac_status.local_fault;

   // ------------------------------
   // Reset-done edge counter
   // ------------------------------
   always_ff @(posedge coreclk) begin
      if (reset) begin
         resetdone_q <= 1'b0;
      end
      else begin
         resetdone_q <= resetdone;
      end
   end

   assign resetdone_rise = resetdone && !resetdone_q;

   // Two bits, rolls over after 3 and drops core_ready again
   always_ff @(posedge coreclk) begin
      if (reset) begin
         resetdone_count <= 2'd0;
      end
      else if (resetdone_rise) begin
         resetdone_count <= resetdone_count + 2'd1;
      end
   end

   // ------------------------------
   // Outputs
   // ------------------------------

   // Ready once the transceiver has come out of reset at least twice
   assign core_ready = block_lock && no_fault && resetdone_count[1];

   // In loopback the pattern generator does not need block lock
   assign pat_gen_start = enable_pat_gen && no_fault && (ctrl.pcs_loopback || block_lock);

endmodule

`default_nettype wire

// File: source/input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module input_sync (
   input  logic                     coreclk,
   input  logic                     reset,
   input  eth_ctrl_pkg::ctrl_sync_t async_in,
   output eth_ctrl_pkg::ctrl_sync_t sync_out
);

   // ------------------------------
   // Two-flop synchronizer
   // ------------------------------

   // First stage may go metastable
   eth_ctrl_pkg::ctrl_sync_t meta_q;

   // Second stage is safe to use in coreclk logic
   eth_ctrl_pkg::ctrl_sync_t sync_q;

   always_ff @(posedge coreclk) begin
      if (reset) begin
         meta_q <= '0;
         sync_q <= '0;
      end
      else begin
         meta_q <= async_in;
         sync_q <= meta_q;
      end
   end

   // Both levels are independent, so no bundle coherency is needed
   assign sync_out = sync_q;

endmodule

`default_nettype wire

// File: source/eth_ctrl_pkg.sv
`default_nettype none

package eth_ctrl_pkg;

   // ------------------------------
   // Widths and fixed settings
   // ------------------------------
   localparam int MAC_CONFIG_WIDTH = 80;
   localparam int PCS_CONFIG_WIDTH = 536;
   localparam int PCS_STATUS_WIDTH = 8;

   // Mode field of both MAC configuration vectors
   localparam logic [1:0] MAC_MODE = 2'b10;
   localparam logic VLAN_ENABLE = 1'b0;

   // Statistics channels, 0 is transmit and 1 is receive
   localparam int NUM_STATS_CH = 2;
   localparam int STATS_MAX_WIDTH = 30;
   localparam int STATS_WIDTH [NUM_STATS_CH] = '{26, 30};

   // Sent ahead of every serialized vector
   localparam logic [1:0] STATS_MARKER = 2'b01;

   // ------------------------------
   // Bundled signals
   // ------------------------------

   // Control levels that cross into coreclk
   typedef struct packed {
      logic pcs_loopback;
      logic custom_preamble;
   } ctrl_sync_t;

   // MAC transmit and receive configuration vector
   typedef struct packed {
      logic [MAC_CONFIG_WIDTH-9:0] reserved_hi;
      logic                        custom_preamble;
      logic [3:0]                  reserved_lo;
      logic                        enable_vlan;
      logic [1:0]                  mode;
   } mac_config_t;

   // PCS/PMA configuration vector, loopback sits at bit 110
   typedef struct packed {
      logic [PCS_CONFIG_WIDTH-112:0] reserved_hi;
      logic                          loopback;
      logic [109:0]                  reserved_lo;
   } pcs_config_t;

   // MAC status, remote fault in bit 0
   typedef struct packed {
      logic rx_fault;
      logic local_fault;
      logic remote_fault;
   } mac_status_t;

   // One statistics channel as the MAC presents it
   typedef struct packed {
      logic                       valid;
      logic [STATS_MAX_WIDTH-1:0] vector;
   } stats_report_t;

endpackage

`default_nettype wire
